// File: ifetch_mem.f
logic/ifetch_pkg.sv
logic/seg_router.sv
logic/icache.sv
logic/axi_rd_bridge.sv
logic/ifetch_mem.sv
tb/tb_axi_mem.sv
tb/tb_ifetch.sv

// File: logic/axi_rd_bridge.sv
module axi_rd_bridge #(
  parameter logic [ifetch_pkg::axi_id_w-1:0] ar_id = '0
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  ifetch_pkg::mem_req_t req,
  output ifetch_pkg::mem_rsp_t rsp,
  output ifetch_pkg::axi_ar_t  ar,
  input  logic                 arready,
  input  ifetch_pkg::axi_r_t   r,
  output logic                 rready
);
  import ifetch_pkg::*;

  typedef enum logic [1:0] {
    s_idle,
    s_addr,
    s_data
  } state_t;

  state_t state;

  logic [addr_w-1:0] araddr_q;
  logic [7:0]        arlen_q;
  logic              accept;

  assign accept = (state == s_idle) & req.req;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: begin
          if (req.req) begin
            state <= s_addr;
          end
        end
        s_addr: begin
          // arvalid held until the slave takes it
          if (arready) begin
            state <= s_data;
          end
        end
        s_data: begin
          if (r.rvalid && r.rlast) begin
            state <= s_idle;
          end
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

  // line refill uses the full burst, uncached a single beat
  always_ff @(posedge clk) begin
    if (accept) begin
      araddr_q <= req.addr.raw;
      arlen_q  <= req.burst ? axi_len_line : 8'd0;
    end
  end

  always_comb begin
    ar.arid    = ar_id;
    ar.araddr  = araddr_q;
    ar.arlen   = arlen_q;
    ar.arsize  = axi_size_word;
    ar.arburst = axi_burst_incr;
    ar.arvalid = (state == s_addr);
  end

  assign rready = (state == s_data);

  // every beat passes through as it is taken
  always_comb begin
    rsp.addr_ok = accept;
    rsp.data_ok = (state == s_data) & r.rvalid;
    rsp.last    = r.rlast;
    rsp.rdata   = r.rdata;
  end

endmodule

// File: logic/icache.sv
module icache (
  input  logic                   clk,
  input  logic                   rst_n,
  input  ifetch_pkg::mem_req_t   req,
  output ifetch_pkg::fetch_rsp_t rsp,
  output ifetch_pkg::mem_req_t   refill_req,
  input  ifetch_pkg::mem_rsp_t   refill_rsp
);
  import ifetch_pkg::*;

  localparam int lines = 1 << index_bits;

  typedef enum logic [1:0] {
    s_idle,
    s_lookup,
    s_refill,
    s_respond
  } state_t;

  state_t state;

  // request address held for the whole lookup and refill
  paddr_u addr_q;

  logic [tag_bits-1:0] tag_mem  [lines];
  logic [data_w-1:0]   data_mem [lines * line_words];
  logic [lines-1:0]    valid;

  logic [offset_bits-1:0] beat_cnt;
  logic                   ar_done;
  logic                   hit;
  logic                   beat;
  logic                   accept;

  assign accept = (state == s_idle) & req.req;

  assign hit = valid[addr_q.f.index] & (tag_mem[addr_q.f.index] == addr_q.f.tag);

  // a refill beat is only counted once the address went out
  assign beat = (state == s_refill) & ar_done & refill_rsp.data_ok;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= s_idle;
      valid    <= '0;
      ar_done  <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (req.req) begin
            state <= s_lookup;
          end
        end
        s_lookup: begin
          if (hit) begin
            state <= s_idle;
          end else begin
            state    <= s_refill;
            ar_done  <= 1'b0;
            beat_cnt <= '0;
          end
        end
        s_refill: begin
          if (refill_rsp.addr_ok) begin
            ar_done <= 1'b1;
          end
          if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (refill_rsp.last) begin
              valid[addr_q.f.index] <= 1'b1;
              state                 <= s_respond;
            end
          end
        end
        s_respond: begin
          state <= s_idle;
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= req.addr;
    end
  end

  // beats arrive in order from the line base
  always_ff @(posedge clk) begin
    if (beat) begin
      data_mem[{addr_q.f.index, beat_cnt}] <= refill_rsp.rdata;
    end
  end

  // tag written with the last beat, together with the valid bit
  always_ff @(posedge clk) begin
    if (beat && refill_rsp.last) begin
      tag_mem[addr_q.f.index] <= addr_q.f.tag;
    end
  end

  // line refill always starts at word 0
  always_comb begin
    refill_req.req             = (state == s_refill) & ~ar_done;
    refill_req.addr            = addr_q;
    refill_req.addr.f.word     = '0;
    refill_req.addr.f.byte_off = '0;
    refill_req.burst           = 1'b1;
  end

  // hit answers from lookup, a miss answers one cycle after the last beat
  always_comb begin
    rsp.addr_ok = accept;
    rsp.data_ok = ((state == s_lookup) & hit) | (state == s_respond);
    rsp.err     = 1'b0;
    rsp.rdata   = data_mem[{addr_q.f.index, addr_q.f.word}];
  end

endmodule

// File: logic/ifetch_mem.sv
module ifetch_mem #(
  parameter logic [ifetch_pkg::axi_id_w-1:0] ar_id = '0
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  ifetch_pkg::fetch_req_t cpu_req,
  output ifetch_pkg::fetch_rsp_t cpu_rsp,
  output ifetch_pkg::axi_ar_t    ar,
  input  logic                   arready,
  input  ifetch_pkg::axi_r_t     r,
  output logic                   rready
);
  import ifetch_pkg::*;

  mem_req_t   cache_req;
  fetch_rsp_t cache_rsp;
  mem_req_t   unc_req;
  mem_req_t   refill_req;
  mem_req_t   bridge_req;
  mem_rsp_t   bridge_rsp;

  // registered in the router for the fetch in flight
  logic cached;

  seg_router router (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu_req   (cpu_req),
    .cpu_rsp   (cpu_rsp),
    .cache_req (cache_req),
    .cache_rsp (cache_rsp),
    .unc_req   (unc_req),
    .unc_rsp   (bridge_rsp),
    .cached    (cached)
  );

  icache cache (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (cache_req),
    .rsp        (cache_rsp),
    .refill_req (refill_req),
    .refill_rsp (bridge_rsp)
  );

  // refill or uncached fetch, never both at once
  assign bridge_req = cached ? refill_req : unc_req;

  axi_rd_bridge #(
    .ar_id (ar_id)
  ) bridge (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (bridge_req),
    .rsp     (bridge_rsp),
    .ar      (ar),
    .arready (arready),
    .r       (r),
    .rready  (rready)
  );

endmodule

// File: logic/ifetch_pkg.sv
package ifetch_pkg;

  // word and address width
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // direct-mapped geometry, 64 lines of 4 words
  localparam int index_bits  = 6;
  localparam int offset_bits = 2;
  localparam int line_words  = 1 << offset_bits;
  localparam int tag_bits    = addr_w - index_bits - offset_bits - 2;

  // top three address bits select the segment
  localparam logic [addr_w-1:0] seg_mask   = 32'he000_0000;
  localparam logic [addr_w-1:0] kseg0_base = 32'h8000_0000;
  localparam logic [addr_w-1:0] kseg1_base = 32'ha000_0000;

  // AXI read channel constants
  localparam int               axi_id_w       = 4;
  localparam logic [7:0]       axi_len_line   = 8'(line_words - 1);
  localparam logic [1:0]       axi_burst_incr = 2'b01;
  localparam logic [2:0]       axi_size_word  = 3'b010;

  // physical address, seen raw or split for the cache
  typedef union packed {
    logic [addr_w-1:0] raw;
    struct packed {
      logic [tag_bits-1:0]    tag;
      logic [index_bits-1:0]  index;
      logic [offset_bits-1:0] word;
      logic [1:0]             byte_off;
    } f;
  } paddr_u;

  typedef struct packed {
    logic              req;
    logic [addr_w-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic              addr_ok;
    logic              data_ok;
    logic              err;
    logic [data_w-1:0] rdata;
  } fetch_rsp_t;

  // burst set means a whole line
  typedef struct packed {
    logic   req;
    paddr_u addr;
    logic   burst;
  } mem_req_t;

  typedef struct packed {
    logic              addr_ok;
    logic              data_ok;
    logic              last;
    logic [data_w-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [axi_id_w-1:0] arid;
    logic [addr_w-1:0]   araddr;
    logic [7:0]          arlen;
    logic [2:0]          arsize;
    logic [1:0]          arburst;
    logic                arvalid;
  } axi_ar_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
    logic              rlast;
    logic              rvalid;
  } axi_r_t;

endpackage

// File: logic/seg_router.sv
module seg_router (
  input  logic                   clk,
  input  logic                   rst_n,
  input  ifetch_pkg::fetch_req_t cpu_req,
  output ifetch_pkg::fetch_rsp_t cpu_rsp,
  output ifetch_pkg::mem_req_t   cache_req,
  input  ifetch_pkg::fetch_rsp_t cache_rsp,
  output ifetch_pkg::mem_req_t   unc_req,
  input  ifetch_pkg::mem_rsp_t   unc_rsp,
  output logic                   cached
);
  import ifetch_pkg::*;

  logic   is_k0;
  logic   is_k1;
  logic   is_err;
  paddr_u paddr;
  paddr_u unc_addr_q;
  logic   busy;
  logic   err_q;
  logic   unc_pend;
  logic   accept;
  logic   done;

  // segment decode on the virtual address
  assign is_k0  = (cpu_req.addr & seg_mask) == kseg0_base;
  assign is_k1  = (cpu_req.addr & seg_mask) == kseg1_base;
  // anything else would need the TLB
  assign is_err = ~(is_k0 | is_k1);

  // unmapped segments just drop the top bits
  assign paddr.raw = cpu_req.addr & ~seg_mask;

  assign accept = cpu_rsp.addr_ok;
  assign done   = cpu_rsp.data_ok;

  // cached fetches go straight to the cache, only while idle
  always_comb begin
    cache_req.req   = cpu_req.req & ~busy & is_k0;
    cache_req.addr  = paddr;
    cache_req.burst = 1'b0;
  end

  // uncached fetch is replayed from the registered address
  always_comb begin
    unc_req.req   = unc_pend;
    unc_req.addr  = unc_addr_q;
    unc_req.burst = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      cached   <= 1'b0;
      err_q    <= 1'b0;
      unc_pend <= 1'b0;
    end else if (accept) begin
      busy     <= 1'b1;
      cached   <= is_k0;
      err_q    <= is_err;
      unc_pend <= is_k1;
    end else begin
      if (done) begin
        busy <= 1'b0;
      end
      if (unc_rsp.addr_ok) begin
        unc_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      unc_addr_q <= paddr;
    end
  end

  // kseg1 and error fetches are accepted here, kseg0 waits for the cache
  always_comb begin
    cpu_rsp.addr_ok = cpu_req.req & ~busy & (~is_k0 | cache_rsp.addr_ok);
    cpu_rsp.data_ok = 1'b0;
    cpu_rsp.err     = 1'b0;
    cpu_rsp.rdata   = unc_rsp.rdata;
    if (busy) begin
      if (err_q) begin
        cpu_rsp.data_ok = 1'b1;
        cpu_rsp.err     = 1'b1;
        cpu_rsp.rdata   = '0;
      end else if (cached) begin
        cpu_rsp.data_ok = cache_rsp.data_ok;
        cpu_rsp.err     = cache_rsp.err;
        cpu_rsp.rdata   = cache_rsp.rdata;
      end else begin
        // single beat, so last comes with the only data_ok
        cpu_rsp.data_ok = unc_rsp.data_ok & unc_rsp.last;
      end
    end
  end

endmodule

// File: tb/fetch_trace.txt
# columns: virtual address, expected word, expected err, burst kind (all hex)
# burst kind: 0 no bus read, 1 single beat, 2 line burst
a0001004 ffffeffb 0 0001
a0000000 ffffffff 0 0001
80002008 ffffdff7 0 0002
8000200c ffffdff3 0 0000
80002000 ffffdfff 0 0000
00400000 00000000 1 0000
c0000010 00000000 1 0000
e0000000 00000000 1 0000
80003040 ffffcfbf 0 0002
80013040 fffecfbf 0 0002
80003044 ffffcfbb 0 0002
80013048 fffecfb7 0 0002
80013044 fffecfbb 0 0000
80003048 ffffcfb7 0 0002
8000304c ffffcfb3 0 0000
a0003040 ffffcfbf 0 0001
80002004 ffffdffb 0 0000
7ffffffc 00000000 1 0000

// File: tb/tb_axi_mem.sv
module tb_axi_mem (
  input  logic                clk,
  input  logic                rst_n,
  input  ifetch_pkg::axi_ar_t ar,
  output logic                arready,
  output ifetch_pkg::axi_r_t  r,
  input  logic                rready,
  output int                  faults
);
  import ifetch_pkg::*;

  int                seed;
  int                gap;
  int                waited;
  logic [addr_w-1:0] base;
  logic [7:0]        len;

  initial begin
    seed    = 32'h23db;
    faults  = 0;
    arready = 1'b0;
    r       = '0;
    forever begin
      @(posedge clk);
      #1;
      if (rst_n && ar.arvalid) begin
        base = ar.araddr;
        len  = ar.arlen;
        // random address phase stall
        gap = {$random(seed)} % 4;
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
        arready = 1'b1;
        @(posedge clk);
        #1;
        arready = 1'b0;
        for (int i = 0; i <= len; i++) begin
          gap = {$random(seed)} % 4;
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
          // data is the inverted byte address of the beat
          r.rdata  = ~(base + 4 * i);
          r.rlast  = (i == len);
          r.rvalid = 1'b1;
          waited   = 0;
          while (!rready && waited < 20) begin
            @(posedge clk);
            #1;
            waited++;
          end
          if (!rready) begin
            faults++;
            $display("read data beat was never accepted, rready stayed low");
          end
          @(posedge clk);
          #1;
          r.rvalid = 1'b0;
          r.rlast  = 1'b0;
        end
      end
    end
  end

endmodule

// File: tb/tb_ifetch.sv
module tb_ifetch;
  import ifetch_pkg::*;

  localparam int max_wait = 200;

  // read ID handed down to the bridge
  localparam logic [3:0] fetch_id = 4'h5;

  logic       clk;
  logic       rst_n;
  fetch_req_t cpu_req;
  fetch_rsp_t cpu_rsp;
  axi_ar_t    ar;
  logic       arready;
  axi_r_t     r;
  logic       rready;
  int         mem_faults;

  int                errors;
  int                checks;
  int                timeouts;
  int                ar_count;
  logic              arv_seen;
  logic [7:0]        ar_len;
  logic [addr_w-1:0] ar_addr;

  ifetch_mem #(
    .ar_id (fetch_id)
  ) UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .cpu_req (cpu_req),
    .cpu_rsp (cpu_rsp),
    .ar      (ar),
    .arready (arready),
    .r       (r),
    .rready  (rready)
  );

  tb_axi_mem axi_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .ar      (ar),
    .arready (arready),
    .r       (r),
    .rready  (rready),
    .faults  (mem_faults)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // AR handshake completes on the edge after this sample
  always @(negedge clk) begin
    if (ar.arvalid === 1'b1) begin
      arv_seen = 1'b1;
      if (arready) begin
        ar_count++;
        ar_len  = ar.arlen;
        ar_addr = ar.araddr;
        // 4-byte beats in an incrementing burst
        compare_word("arid", ar.arid, fetch_id);
        compare_word("arsize", ar.arsize, 3'b010);
        compare_word("arburst", ar.arburst, 2'b01);
      end
    end
  end

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic run_fetch(input logic [31:0] vaddr, input logic [31:0] exp_word,
                           input logic exp_err, input logic [31:0] kind);
    logic [addr_w-1:0] paddr;
    int                waited;
    int                lat;
    // unmapped segments drop the top three bits
    paddr        = vaddr & 32'h1fff_ffff;
    ar_count     = 0;
    arv_seen     = 1'b0;
    cpu_req.req  = 1'b1;
    cpu_req.addr = vaddr;
    waited       = 0;
    @(negedge clk);
    while (!cpu_rsp.addr_ok && waited < max_wait) begin
      @(negedge clk);
      waited++;
    end
    if (!cpu_rsp.addr_ok) begin
      timeouts++;
      $display("fetch at %h was never accepted", vaddr);
      return;
    end
    @(posedge clk);
    #1;
    cpu_req = '0;
    lat     = 1;
    @(negedge clk);
    while (!cpu_rsp.data_ok && lat < max_wait) begin
      @(negedge clk);
      lat++;
    end
    if (!cpu_rsp.data_ok) begin
      timeouts++;
      $display("fetch at %h never returned data", vaddr);
      return;
    end
    compare_word("err", cpu_rsp.err, exp_err);
    if (!exp_err) begin
      compare_word("rdata", cpu_rsp.rdata, exp_word);
    end
    case (kind)
      0: begin
        // hit or error, answered without the bus
        compare_word("data_ok latency", lat, 1);
        compare_word("arvalid", arv_seen, 0);
      end
      1: begin
        compare_word("ar count", ar_count, 1);
        compare_word("arlen", ar_len, 0);
        compare_word("araddr", ar_addr, paddr);
      end
      2: begin
        compare_word("ar count", ar_count, 1);
        compare_word("arlen", ar_len, 3);
        compare_word("araddr", ar_addr, paddr & ~32'hf);
      end
      default: begin
        errors++;
        $display("trace line for %h has an unknown burst kind", vaddr);
      end
    endcase
    @(posedge clk);
    #1;
  endtask

  initial begin
    int          fd;
    int          code;
    int          fields;
    string       line;
    logic [31:0] vaddr;
    logic [31:0] exp_word;
    logic [31:0] exp_err;
    logic [31:0] kind;
    errors   = 0;
    checks   = 0;
    timeouts = 0;
    ar_count = 0;
    arv_seen = 1'b0;
    ar_len   = '0;
    ar_addr  = '0;
    cpu_req  = '0;
    rst_n    = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // quiet outputs with no request
    repeat (4) begin
      @(negedge clk);
      compare_word("addr_ok", cpu_rsp.addr_ok, 0);
      compare_word("data_ok", cpu_rsp.data_ok, 0);
      compare_word("arvalid", ar.arvalid, 0);
      compare_word("rready", rready, 0);
    end
    @(posedge clk);
    #1;
    fd = $fopen("tb/fetch_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the fetch trace file");
    end else begin
      while (!$feof(fd) && timeouts == 0) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%h %h %h %h", vaddr, exp_word, exp_err, kind);
          if (fields == 4) begin
            run_fetch(vaddr, exp_word, exp_err[0], kind);
          end
        end
      end
      $fclose(fd);
    end
    errors += mem_faults;
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
